//--- Bender.yml
package:
  name: system86_video

sources:
  - common/video_pkg.sv
  - common/video_timing_if.sv
  - timing/video_timing.sv
  - logic/host_regs.sv
  - tilegen/tile_layer.sv
  - clut/color_lut.sv
  - logic/system86_video.sv
  - target: test
    files:
      - bench/tb_clock.sv
      - bench/tb_system86_video.sv

//--- bench/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
	output logic clk,
	output logic reset
);

	// 8 ns period, stands in for clk_48m
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// reset held for 10 cycles, released on a falling edge
	initial begin
		reset = 1'b1;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

`default_nettype wire

//--- bench/tb_system86_video.sv
`timescale 1ns/1ns
`default_nettype none

module tb_system86_video;
	import video_pkg::*;

	localparam int frame_pixels = h_total * v_total;
	localparam int frame_cycles = frame_pixels * pix_div;
	// four vblank waits and one frame of slack
	localparam int timeout_cycles = 5 * frame_cycles;
	// first checked pixel of line v_active
	localparam int vblank_pix = v_active * h_total;

	logic clk_48m;
	logic reset;
	logic we;
	logic [12:0] addr;
	logic [7:0] wdata;
	logic [3:0] r;
	logic [3:0] g;
	logic [3:0] b;
	logic hsync;
	logic vsync;
	logic pix_en;

	// shadow of the host visible state
	bus_data_t tile_mem [tile_size];
	bus_data_t pal_rg_mem [pal_size];
	bus_data_t pal_b_mem [pal_size];
	scroll_x_t sh_sx;
	scroll_y_t sh_sy;
	color_idx_t sh_bc;

	integer seed;
	int errors = 0;
	int cycles = 0;
	int n_pix = 0;
	int gap = 0;
	logic pending = 1'b0;
	logic loaded = 1'b0;
	event vblank_ev;

	tb_clock tb_clock_i (
		.clk   (clk_48m),
		.reset (reset)
	);

	system86_video system86_video_i (
		.clk_48m (clk_48m),
		.reset   (reset),
		.we      (we),
		.addr    (addr),
		.wdata   (wdata),
		.r       (r),
		.g       (g),
		.b       (b),
		.hsync   (hsync),
		.vsync   (vsync),
		.pix_en  (pix_en)
	);

	//////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////

	// address map applied to the shadow
	function automatic void model_write(input bus_addr_t a, input bus_data_t d);
		if (a >= tile_base && a < tile_base + tile_size)
			tile_mem[a - tile_base] = d;
		else if (a >= pal_rg_base && a < pal_rg_base + pal_size)
			pal_rg_mem[a - pal_rg_base] = d;
		else if (a >= pal_b_base && a < pal_b_base + pal_size)
			pal_b_mem[a - pal_b_base] = d;
		else if (a == reg_scroll_x_lo)
			sh_sx[7:0] = d;
		else if (a == reg_scroll_x_hi)
			sh_sx[8] = d[0];
		else if (a == reg_scroll_y)
			sh_sy = d;
		else if (a == reg_backcolor)
			sh_bc = d;
	endfunction

	function automatic logic is_blank(input int pix);
		return ((pix % h_total) >= h_active) || ((pix / h_total) >= v_active);
	endfunction

	// {r, g, b, hsync, vsync} for one scan position
	function automatic logic [13:0] ref_pixel(input int pix);
		int h;
		int v;
		int col;
		int row;
		color_idx_t idx;
		logic [13:0] res;
		h = pix % h_total;
		v = pix / h_total;
		col = ((h + sh_sx) / 8) % tile_cols;
		row = ((v + sh_sy) / 8) % tile_rows;
		idx = tile_mem[row * tile_cols + col];
		// transparent tile takes the backcolor
		if (idx == 8'h00)
			idx = sh_bc;
		if (is_blank(pix))
			res[13:2] = '0;
		else
			res[13:2] = {pal_rg_mem[idx], pal_b_mem[idx][3:0]};
		res[1] = (h >= hsync_start) && (h < hsync_start + hsync_len);
		res[0] = (v >= vsync_start) && (v < vsync_start + vsync_len);
		return res;
	endfunction

	//////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////

	task automatic fail_stop();
		errors++;
		$display("Some tests failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_rgb(input string name, input nibble_t got, input nibble_t exp,
			input int pix);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %h expected %h at h %0d v %0d",
				name, got, exp, pix % h_total, pix / h_total);
			fail_stop();
		end
	endtask

	task automatic check_sync(input string name, input logic got, input logic exp,
			input int pix);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %h expected %h at h %0d v %0d",
				name, got, exp, pix % h_total, pix / h_total);
			fail_stop();
		end
	endtask

	//////////////////////////////////////////////////
	// output checker
	//////////////////////////////////////////////////

	// outputs settle the cycle after a pix_en and belong to pixel n-2
	always @(negedge clk_48m) begin
		int pix;
		logic [13:0] exp;
		if (reset) begin
			n_pix = 0;
			pending = 1'b0;
			gap = 0;
		end else if (pix_en) begin
			// one pulse in every pix_div cycles
			if (n_pix > 0 && gap != pix_div - 1) begin
				$display("pix_en came %0d cycles after the previous pulse instead of %0d",
					gap + 1, pix_div);
				fail_stop();
			end
			n_pix++;
			pending = 1'b1;
			gap = 0;
		end else begin
			gap++;
			if (pending) begin
				pending = 1'b0;
				if (n_pix >= 2) begin
					pix = (n_pix - 2) % frame_pixels;
					exp = ref_pixel(pix);
					// rgb is known once the RAMs are loaded or while blank
					if (loaded || is_blank(pix)) begin
						check_rgb("r", r, exp[13:10], pix);
						check_rgb("g", g, exp[9:6], pix);
						check_rgb("b", b, exp[5:2], pix);
					end
					// sync edges land where the rule puts them
					check_sync("hsync", hsync, exp[1], pix);
					check_sync("vsync", vsync, exp[0], pix);
					if (pix == vblank_pix)
						-> vblank_ev;
				end
			end
		end
	end

	// cycle limit
	always @(posedge clk_48m) begin
		cycles++;
		if (cycles >= timeout_cycles) begin
			$display("timeout, the run did not finish within %0d cycles", timeout_cycles);
			$display("Some tests failed");
			$fatal(1, "timeout");
		end
	end

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////

	// one write per cycle on the falling edge
	task automatic host_write(input bus_addr_t a, input bus_data_t d);
		@(negedge clk_48m);
		we = 1'b1;
		addr = a;
		wdata = d;
		model_write(a, d);
	endtask

	task automatic bus_idle();
		@(negedge clk_48m);
		we = 1'b0;
	endtask

	initial begin
		bus_data_t d;
		we = 1'b0;
		addr = '0;
		wdata = '0;
		seed = 32'h5be5;
		sh_sx = '0;
		sh_sy = '0;
		sh_bc = '0;

		// test 1 checks quiet outputs straight out of reset
		@(negedge reset);
		@(negedge clk_48m);
		check_rgb("r", r, 4'h0, 0);
		check_rgb("g", g, 4'h0, 0);
		check_rgb("b", b, 4'h0, 0);
		check_sync("hsync", hsync, 1'b0, 0);
		check_sync("vsync", vsync, 1'b0, 0);
		check_sync("pix_en", pix_en, 1'b0, 0);

		// tests 2 and 3 load random tiles and palette in frame 0 vblank
		@(vblank_ev);
		for (int i = 0; i < tile_size; i++) begin
			d = $random(seed);
			// sprinkle transparent tiles
			if (i % 29 == 0)
				d = 8'h00;
			host_write(tile_base + i, d);
		end
		for (int i = 0; i < pal_size; i++) begin
			host_write(pal_rg_base + i, $random(seed));
			host_write(pal_b_base + i, $random(seed));
		end
		host_write(reg_backcolor, 8'h5a);
		bus_idle();
		loaded = 1'b1;

		// frame 1 checked by now, so new backcolor and stray writes for frame 2
		@(vblank_ev);
		host_write(reg_backcolor, 8'hc3);
		// test 6 writes to unmapped holes in the map
		host_write(13'h0800, $random(seed));
		host_write(13'h0abc, $random(seed));
		host_write(13'h0fff, $random(seed));
		host_write(13'h1200, $random(seed));
		host_write(13'h17ff, $random(seed));
		host_write(13'h1804, $random(seed));
		host_write(13'h1a00, $random(seed));
		host_write(13'h1fff, $random(seed));
		bus_idle();

		// test 4 sets the high bit of scroll_x and scroll_y near its wrap
		@(vblank_ev);
		host_write(reg_scroll_x_lo, 8'ha5);
		// only bit 0 counts here
		host_write(reg_scroll_x_hi, 8'hff);
		host_write(reg_scroll_y, 8'hfc);
		bus_idle();

		// frame 3 active area checked under scroll
		@(vblank_ev);
		if (errors == 0) begin
			$display("All tests passed");
			$finish;
		end else begin
			$display("Some tests failed");
			$fatal(1, "errors seen");
		end
	end

endmodule

`default_nettype wire

//--- clut/color_lut.sv
`timescale 1ns/1ns
`default_nettype none

module color_lut (
	input logic clk_48m,
	input logic reset,
	input logic pix_en,
	input video_pkg::color_idx_t dot,
	input logic dot_blank,
	input logic pal_rg_we,
	input logic pal_b_we,
	input video_pkg::tile_addr_t wr_addr,
	input video_pkg::bus_data_t wr_data,
	input video_pkg::color_idx_t backcolor,
	output video_pkg::nibble_t r,
	output video_pkg::nibble_t g,
	output video_pkg::nibble_t b
);
	import video_pkg::*;

	// red high nibble, green low nibble
	bus_data_t pal_rg [pal_size];
	// blue only
	nibble_t pal_b [pal_size];

	color_idx_t pal_addr;
	color_idx_t idx;
	bus_data_t rg_entry;
	nibble_t b_entry;

	//////////////////////////////////////////////////
	// palette write
	//////////////////////////////////////////////////

	// palette offset fits in the low byte
	assign pal_addr = color_idx_t'(wr_addr);

	always_ff @(posedge clk_48m) begin
		if (pal_rg_we)
			pal_rg[pal_addr] <= wr_data;
		if (pal_b_we)
			pal_b[pal_addr] <= wr_data[3:0];
	end

	//////////////////////////////////////////////////
	// lookup and rgb register
	//////////////////////////////////////////////////

	// transparent tile shows the backcolor
	assign idx = (dot == transparent_idx) ? backcolor : dot;
	assign rg_entry = pal_rg[idx];
	assign b_entry = pal_b[idx];

	always_ff @(posedge clk_48m) begin
		if (reset) begin
			r <= '0;
			g <= '0;
			b <= '0;
		end else if (pix_en) begin
			// black outside the active window
			if (dot_blank) begin
				r <= '0;
				g <= '0;
				b <= '0;
			end else begin
				r <= rg_entry[7:4];
				g <= rg_entry[3:0];
				b <= b_entry;
			end
		end
	end

endmodule

`default_nettype wire

//--- common/video_pkg.sv
`default_nettype none

package video_pkg;

	//////////////////////////////////////////////////
	// screen timing
	//////////////////////////////////////////////////

	// pixel and line counts
	localparam int h_total  = 384;
	localparam int h_active = 288;
	localparam int v_total  = 264;
	localparam int v_active = 224;

	// sync windows, both active high
	localparam int hsync_start = 300;
	localparam int hsync_len   = 32;
	localparam int vsync_start = 240;
	localparam int vsync_len   = 4;

	// clk_48m cycles per pixel, 48M down to 6M
	localparam int pix_div = 8;
	// pixels from counter to rgb register
	localparam int pipe_delay = 2;

	// tilemap is 64x32 tiles of 8x8 pixels
	localparam int tile_cols = 64;
	localparam int tile_rows = 32;
	localparam int tile_size = tile_cols * tile_rows;
	localparam int pal_size  = 256;

	//////////////////////////////////////////////////
	// types
	//////////////////////////////////////////////////

	typedef logic [8:0]  hpos_t;
	typedef logic [8:0]  vpos_t;
	typedef logic [8:0]  scroll_x_t;
	typedef logic [7:0]  scroll_y_t;
	typedef logic [7:0]  color_idx_t;
	typedef logic [3:0]  nibble_t;
	// same widths as the board's A and D
	typedef logic [12:0] bus_addr_t;
	typedef logic [7:0]  bus_data_t;
	typedef logic [10:0] tile_addr_t;

	// host address map
	localparam bus_addr_t tile_base       = 13'h0000;
	localparam bus_addr_t pal_rg_base     = 13'h1000;
	localparam bus_addr_t pal_b_base      = 13'h1100;
	localparam bus_addr_t reg_scroll_x_lo = 13'h1800;
	localparam bus_addr_t reg_scroll_x_hi = 13'h1801;
	localparam bus_addr_t reg_scroll_y    = 13'h1802;
	localparam bus_addr_t reg_backcolor   = 13'h1803;

	// index that shows the backcolor
	localparam color_idx_t transparent_idx = 8'h00;

	typedef enum logic {idle, sync} sync_state_t;

endpackage

`default_nettype wire

//--- common/video_timing_if.sv
`timescale 1ns/1ns
`default_nettype none

interface video_timing_if;
	import video_pkg::*;

	// one clk_48m cycle in eight
	logic pix_en;
	// scan position, valid while pix_en
	hpos_t hpos;
	vpos_t vpos;
	// outside the 288x224 window
	logic blank;

	modport source (
		output pix_en, hpos, vpos, blank
	);

	modport sink (
		input pix_en, hpos, vpos, blank
	);

endinterface

`default_nettype wire

//--- flist.f
common/video_pkg.sv
common/video_timing_if.sv
timing/video_timing.sv
logic/host_regs.sv
tilegen/tile_layer.sv
clut/color_lut.sv
logic/system86_video.sv
bench/tb_clock.sv
bench/tb_system86_video.sv

//--- logic/host_regs.sv
`timescale 1ns/1ns
`default_nettype none

module host_regs (
	input logic clk_48m,
	input logic reset,
	input logic we,
	input video_pkg::bus_addr_t addr,
	input video_pkg::bus_data_t wdata,
	output logic tile_we,
	output logic pal_rg_we,
	output logic pal_b_we,
	output video_pkg::tile_addr_t wr_addr,
	output video_pkg::bus_data_t wr_data,
	output video_pkg::scroll_x_t scroll_x,
	output video_pkg::scroll_y_t scroll_y,
	output video_pkg::color_idx_t backcolor
);
	import video_pkg::*;

	bus_addr_t tile_off;
	bus_addr_t rg_off;
	bus_addr_t b_off;
	logic tile_sel;
	logic rg_sel;
	logic b_sel;

	// offsets into each region wrap high when out of range
	assign tile_off = addr - tile_base;
	assign rg_off   = addr - pal_rg_base;
	assign b_off    = addr - pal_b_base;
	assign tile_sel = (tile_off < tile_size);
	assign rg_sel   = (rg_off < pal_size);
	assign b_sel    = (b_off < pal_size);

	//////////////////////////////////////////////////
	// strobes and latches
	//////////////////////////////////////////////////

	always_ff @(posedge clk_48m) begin
		if (reset) begin
			tile_we   <= 1'b0;
			pal_rg_we <= 1'b0;
			pal_b_we  <= 1'b0;
			scroll_x  <= '0;
			scroll_y  <= '0;
			backcolor <= '0;
		end else begin
			tile_we   <= we && tile_sel;
			pal_rg_we <= we && rg_sel;
			pal_b_we  <= we && b_sel;
			// like the SCROLL, LATCH and BACKCOLOR selects
			if (we) begin
				case (addr)
					reg_scroll_x_lo: scroll_x[7:0] <= wdata;
					reg_scroll_x_hi: scroll_x[8] <= wdata[0];
					reg_scroll_y:    scroll_y <= wdata;
					reg_backcolor:   backcolor <= wdata;
					default: ;
				endcase
			end
		end
	end

	// offset and data ride along with the strobe
	// palette offsets sit in the same low byte
	always_ff @(posedge clk_48m) begin
		wr_addr <= tile_addr_t'(tile_off);
		wr_data <= wdata;
	end

endmodule

`default_nettype wire

//--- logic/system86_video.sv
`timescale 1ns/1ns
`default_nettype none

module system86_video (
	input logic clk_48m,
	input logic reset,
	input logic we,
	input logic [12:0] addr,
	input logic [7:0] wdata,
	output logic [3:0] r,
	output logic [3:0] g,
	output logic [3:0] b,
	output logic hsync,
	output logic vsync,
	output logic pix_en
);
	import video_pkg::*;

	// host write path
	logic tile_we;
	logic pal_rg_we;
	logic pal_b_we;
	tile_addr_t wr_addr;
	bus_data_t wr_data;
	scroll_x_t scroll_x;
	scroll_y_t scroll_y;
	color_idx_t backcolor;

	// tile to clut
	color_idx_t dot;
	logic dot_blank;

	video_timing_if vt ();

	//////////////////////////////////////////////////
	// subsystems
	//////////////////////////////////////////////////

	video_timing video_timing_i (
		.clk_48m (clk_48m),
		.reset   (reset),
		.vt      (vt.source),
		.hsync   (hsync),
		.vsync   (vsync)
	);

	host_regs host_regs_i (
		.clk_48m   (clk_48m),
		.reset     (reset),
		.we        (we),
		.addr      (addr),
		.wdata     (wdata),
		.tile_we   (tile_we),
		.pal_rg_we (pal_rg_we),
		.pal_b_we  (pal_b_we),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.scroll_x  (scroll_x),
		.scroll_y  (scroll_y),
		.backcolor (backcolor)
	);

	tile_layer tile_layer_i (
		.clk_48m   (clk_48m),
		.vt        (vt.sink),
		.tile_we   (tile_we),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.scroll_x  (scroll_x),
		.scroll_y  (scroll_y),
		.dot       (dot),
		.dot_blank (dot_blank)
	);

	color_lut color_lut_i (
		.clk_48m   (clk_48m),
		.reset     (reset),
		.pix_en    (vt.pix_en),
		.dot       (dot),
		.dot_blank (dot_blank),
		.pal_rg_we (pal_rg_we),
		.pal_b_we  (pal_b_we),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.backcolor (backcolor),
		.r         (r),
		.g         (g),
		.b         (b)
	);

	// pixel clock out, as CLK_6M goes to J5
	assign pix_en = vt.pix_en;

endmodule

`default_nettype wire

//--- tilegen/tile_layer.sv
`timescale 1ns/1ns
`default_nettype none

module tile_layer (
	input logic clk_48m,
	video_timing_if.sink vt,
	input logic tile_we,
	input video_pkg::tile_addr_t wr_addr,
	input video_pkg::bus_data_t wr_data,
	input video_pkg::scroll_x_t scroll_x,
	input video_pkg::scroll_y_t scroll_y,
	output video_pkg::color_idx_t dot,
	output logic dot_blank
);
	import video_pkg::*;

	// 64x32 tilemap, row-major, one byte per tile
	color_idx_t tile_ram [tile_size];

	hpos_t sx;
	vpos_t sy;
	tile_addr_t rd_addr;

	//////////////////////////////////////////////////
	// host write port
	//////////////////////////////////////////////////

	always_ff @(posedge clk_48m) begin
		if (tile_we)
			tile_ram[wr_addr] <= wr_data;
	end

	//////////////////////////////////////////////////
	// scrolled fetch
	//////////////////////////////////////////////////

	// scroll applied fresh every pixel
	assign sx = vt.hpos + scroll_x;
	assign sy = vt.vpos + vpos_t'(scroll_y);

	// row from sy[7:3] wraps at 32,
	// column from sx[8:3] wraps at 64
	assign rd_addr = {sy[7:3], sx[8:3]};

	// tile byte is the color index,
	// no pattern rom in this model
	always_ff @(posedge clk_48m) begin
		if (vt.pix_en) begin
			dot <= tile_ram[rd_addr];
			// blank follows its pixel
			dot_blank <= vt.blank;
		end
	end

endmodule

`default_nettype wire

//--- timing/video_timing.sv
`timescale 1ns/1ns
`default_nettype none

module video_timing (
	input logic clk_48m,
	input logic reset,
	video_timing_if.source vt,
	output logic hsync,
	output logic vsync
);
	import video_pkg::*;

	logic [$clog2(pix_div)-1:0] div_cnt;
	logic hs_raw;
	logic vs_raw;
	sync_state_t hs_pipe [pipe_delay];
	sync_state_t vs_pipe [pipe_delay];

	//////////////////////////////////////////////////
	// pixel enable, the CLK_6M equivalent
	//////////////////////////////////////////////////

	// first pulse lands 8 cycles out of reset
	always_ff @(posedge clk_48m) begin
		if (reset) begin
			div_cnt <= '0;
			vt.pix_en <= 1'b0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
			vt.pix_en <= (div_cnt == pix_div - 1);
		end
	end

	//////////////////////////////////////////////////
	// h/v counters
	//////////////////////////////////////////////////

	// counters hold the pixel shown by the current pix_en
	always_ff @(posedge clk_48m) begin
		if (reset) begin
			vt.hpos <= '0;
			vt.vpos <= '0;
		end else if (vt.pix_en) begin
			if (vt.hpos == hpos_t'(h_total - 1)) begin
				vt.hpos <= '0;
				// end of frame
				if (vt.vpos == vpos_t'(v_total - 1))
					vt.vpos <= '0;
				else
					vt.vpos <= vt.vpos + 1'b1;
			end else begin
				vt.hpos <= vt.hpos + 1'b1;
			end
		end
	end

	assign vt.blank = (vt.hpos >= h_active) || (vt.vpos >= v_active);

	// raw sync windows on the counters
	assign hs_raw = (vt.hpos >= hsync_start) && (vt.hpos < hsync_start + hsync_len);
	assign vs_raw = (vt.vpos >= vsync_start) && (vt.vpos < vsync_start + vsync_len);

	// delay by the tile and palette stages
	always_ff @(posedge clk_48m) begin
		if (reset) begin
			for (int i = 0; i < pipe_delay; i++) begin
				hs_pipe[i] <= idle;
				vs_pipe[i] <= idle;
			end
		end else if (vt.pix_en) begin
			hs_pipe[0] <= hs_raw ? sync : idle;
			vs_pipe[0] <= vs_raw ? sync : idle;
			for (int i = 1; i < pipe_delay; i++) begin
				hs_pipe[i] <= hs_pipe[i-1];
				vs_pipe[i] <= vs_pipe[i-1];
			end
		end
	end

	assign hsync = (hs_pipe[pipe_delay-1] == sync);
	assign vsync = (vs_pipe[pipe_delay-1] == sync);

endmodule

`default_nettype wire
